// ==== hw/ex_config.svh ====
// Global widths and depths for the integer execute stage.
// XLEN must be a multiple of MULT_STAGES, and MULT_STAGES must be at least 2.
// CDB_CREDITS must match the number of buffer entries at the CDB consumer.

`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Datapath width
`define XLEN 64

// Physical register tag width
`define PRF_IDX 6

// Reorder buffer index width
`define ROB_IDX 5

// Multiplier depth, XLEN/MULT_STAGES multiplier bits per stage
`define MULT_STAGES 8

// CDB credits available after reset
`define CDB_CREDITS 2

`endif

// ==== hw/ex_pkg.sv ====
// Types shared by the execute stage units and the CDB arbiter.
// Operands arrive already selected by issue, so requests carry plain values.

`include "ex_config.svh"

package ex_pkg;

	// ALU operation codes
	typedef enum logic [4:0] {
		alu_addq   = 5'h00,
		alu_subq   = 5'h01,
		alu_and    = 5'h02,
		alu_bic    = 5'h03,
		alu_bis    = 5'h04,
		alu_ornot  = 5'h05,
		alu_xor    = 5'h06,
		alu_eqv    = 5'h07,
		alu_srl    = 5'h08,
		alu_sll    = 5'h09,
		alu_sra    = 5'h0a,
		alu_cmpult = 5'h0b,
		alu_cmpeq  = 5'h0c,
		alu_cmpule = 5'h0d,
		alu_cmplt  = 5'h0e,
		alu_cmple  = 5'h0f
	} alu_func_t;

	// Destination register and ROB slot of an instruction
	typedef struct packed {
		logic [`PRF_IDX-1:0] pdest_idx;
		logic [`ROB_IDX-1:0] rob_idx;
	} ex_tag_t;

	typedef struct packed {
		logic             valid;
		alu_func_t        func;
		logic [2:0]       br_func;
		logic             is_branch;
		logic [`XLEN-1:0] opa;
		logic [`XLEN-1:0] opb;
		logic [`XLEN-1:0] cond_val;
		ex_tag_t          tag;
	} alu_req_t;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] mplier;
		logic [`XLEN-1:0] mcand;
		ex_tag_t          tag;
	} mult_req_t;

	typedef struct packed {
		logic [`XLEN-1:0] value;
		logic             br_taken;
		ex_tag_t          tag;
	} alu_res_t;

	typedef struct packed {
		logic [`XLEN-1:0] value;
		ex_tag_t          tag;
	} mult_res_t;

	// Contents of one multiplier pipeline register
	typedef struct packed {
		logic             valid;
		ex_tag_t          tag;
		logic [`XLEN-1:0] prod;
		logic [`XLEN-1:0] mplier;
		logic [`XLEN-1:0] mcand;
	} mult_stage_t;

	typedef struct packed {
		logic             valid;
		ex_tag_t          tag;
		logic [`XLEN-1:0] value;
		logic             br_taken;
	} cdb_t;

endpackage

// ==== hw/result_slot.sv ====
// Single-entry result holding register between a unit and the CDB arbiter.
// The producer must only load while ready is high, or the entry is overwritten.

`timescale 1ns/1ps

module result_slot #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     load,
	input  payload_t load_data,
	input  logic     grant,
	output logic     valid,
	output payload_t data,
	output logic     ready
);

	// Free now, or freed by the grant on this edge
	assign ready = ~valid | grant;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end else if (grant) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			data <= load_data;
		end
	end

endmodule

// ==== hw/alu_unit.sv ====
// One-cycle integer ALU with branch-condition evaluation.
// Issue must only assert req.valid while free is high.
// Shifts use the low log2(XLEN) bits of opb; unknown func codes give zero.

`timescale 1ns/1ps
`include "ex_config.svh"

module alu_unit (
	input  logic             clk,
	input  logic             reset,
	input  ex_pkg::alu_req_t req,
	input  logic             grant,
	output logic             res_valid,
	output ex_pkg::alu_res_t res,
	output logic             free
);
	import ex_pkg::*;

	localparam int SHW = $clog2(`XLEN);

	logic [`XLEN-1:0] result;
	logic             cond;
	alu_res_t         slot_in;

	// Signed less-than built from an unsigned compare
	function automatic logic signed_lt(logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
		if (a[`XLEN-1] == b[`XLEN-1])
			return a < b;
		else
			return a[`XLEN-1];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Arithmetic and logic
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (req.func)
			alu_addq:   result = req.opa + req.opb;
			alu_subq:   result = req.opa - req.opb;
			alu_and:    result = req.opa & req.opb;
			alu_bic:    result = req.opa & ~req.opb;
			alu_bis:    result = req.opa | req.opb;
			alu_ornot:  result = req.opa | ~req.opb;
			alu_xor:    result = req.opa ^ req.opb;
			alu_eqv:    result = req.opa ^ ~req.opb;
			alu_srl:    result = req.opa >> req.opb[SHW-1:0];
			alu_sll:    result = req.opa << req.opb[SHW-1:0];
			alu_sra:    result = $signed(req.opa) >>> req.opb[SHW-1:0];
			alu_cmpult: result = {{(`XLEN-1){1'b0}}, req.opa < req.opb};
			alu_cmpeq:  result = {{(`XLEN-1){1'b0}}, req.opa == req.opb};
			alu_cmpule: result = {{(`XLEN-1){1'b0}}, req.opa <= req.opb};
			alu_cmplt:  result = {{(`XLEN-1){1'b0}}, signed_lt(req.opa, req.opb)};
			alu_cmple:  result = {{(`XLEN-1){1'b0}},
				signed_lt(req.opa, req.opb) | (req.opa == req.opb)};
			default:    result = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Branch condition on cond_val
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (req.br_func[1:0])
			2'b00: cond = ~req.cond_val[0];
			2'b01: cond = (req.cond_val == '0);
			2'b10: cond = req.cond_val[`XLEN-1];
			default: cond = req.cond_val[`XLEN-1] | (req.cond_val == '0);
		endcase
		// Bit 2 selects the inverted test
		if (req.br_func[2])
			cond = ~cond;
	end

	assign slot_in.value    = result;
	assign slot_in.br_taken = req.is_branch & cond;
	assign slot_in.tag      = req.tag;

	result_slot #(
		.payload_t(alu_res_t)
	) slot_i (
		.clk      (clk),
		.reset    (reset),
		.load     (req.valid),
		.load_data(slot_in),
		.grant    (grant),
		.valid    (res_valid),
		.data     (res),
		.ready    (free)
	);

endmodule

// ==== hw/mult_pipe.sv ====
// Pipelined multiplier, XLEN/MULT_STAGES multiplier bits per stage.
// Keeps the low XLEN bits of the product. MULT_STAGES-1 registers plus the
// result slot hold up to MULT_STAGES operations. The whole pipe stalls
// when its last register is valid and the slot cannot take the result.

`timescale 1ns/1ps
`include "ex_config.svh"

module mult_pipe (
	input  logic              clk,
	input  logic              reset,
	input  ex_pkg::mult_req_t req,
	input  logic              grant,
	output logic              res_valid,
	output ex_pkg::mult_res_t res,
	output logic              free
);
	import ex_pkg::*;

	localparam int STEP = `XLEN / `MULT_STAGES;
	localparam int LAST = `MULT_STAGES - 2;

	mult_stage_t stage_in;
	mult_stage_t stage_q [`MULT_STAGES-1];
	mult_stage_t final_out;
	mult_res_t   slot_in;
	logic        slot_ready;
	logic        hold;

	// One partial product added, operands shifted for the next stage
	function automatic mult_stage_t stage_step(mult_stage_t s);
		mult_stage_t n;
		n        = s;
		n.prod   = s.prod + (s.mcand * {{(`XLEN-STEP){1'b0}}, s.mplier[STEP-1:0]});
		n.mplier = s.mplier >> STEP;
		n.mcand  = s.mcand << STEP;
		return n;
	endfunction

	always_comb begin
		stage_in.valid  = req.valid;
		stage_in.tag    = req.tag;
		stage_in.prod   = '0;
		stage_in.mplier = req.mplier;
		stage_in.mcand  = req.mcand;
	end

	assign hold = stage_q[LAST].valid & ~slot_ready;
	assign free = ~hold;

	//////////////////////////////////////////////////////////////////////
	// Stage registers, all frozen together during a stall
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i <= LAST; i++)
				stage_q[i].valid <= 1'b0;
		end else if (!hold) begin
			stage_q[0] <= stage_step(stage_in);
			for (int i = 1; i <= LAST; i++)
				stage_q[i] <= stage_step(stage_q[i-1]);
		end
	end

	// Final stage writes straight into the slot
	assign final_out     = stage_step(stage_q[LAST]);
	assign slot_in.value = final_out.prod;
	assign slot_in.tag   = final_out.tag;

	result_slot #(
		.payload_t(mult_res_t)
	) slot_i (
		.clk      (clk),
		.reset    (reset),
		.load     (final_out.valid & slot_ready),
		.load_data(slot_in),
		.grant    (grant),
		.valid    (res_valid),
		.data     (res),
		.ready    (slot_ready)
	);

endmodule

// ==== hw/cdb_arbiter.sv ====
// CDB arbiter with credit-based flow control toward the consumer.
// One broadcast per cycle, multiplier first since it holds the older op.
// The consumer must never return more credits than it was given.

`timescale 1ns/1ps
`include "ex_config.svh"

module cdb_arbiter (
	input  logic              clk,
	input  logic              reset,
	input  logic              alu_valid,
	input  ex_pkg::alu_res_t  alu_res,
	input  logic              mult_valid,
	input  ex_pkg::mult_res_t mult_res,
	input  logic              cdb_credit,
	output logic              alu_grant,
	output logic              mult_grant,
	output ex_pkg::cdb_t      cdb
);

	localparam int CW = $clog2(`CDB_CREDITS + 1);

	logic [CW-1:0] credits;
	logic          have_credit;
	logic          send;

	assign have_credit = (credits != '0);
	assign mult_grant  = mult_valid & have_credit;
	assign alu_grant   = alu_valid & have_credit & ~mult_valid;
	assign send        = alu_grant | mult_grant;

	//////////////////////////////////////////////////////////////////////
	// Credit counter
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			credits <= CW'(`CDB_CREDITS);
		else if (send && !cdb_credit)
			credits <= credits - 1'b1;
		else if (!send && cdb_credit)
			credits <= credits + 1'b1;
	end

	// Registered broadcast
	always_ff @(posedge clk) begin
		if (reset) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= send;
			if (mult_grant) begin
				cdb.tag      <= mult_res.tag;
				cdb.value    <= mult_res.value;
				cdb.br_taken <= 1'b0;
			end else if (alu_grant) begin
				cdb.tag      <= alu_res.tag;
				cdb.value    <= alu_res.value;
				cdb.br_taken <= alu_res.br_taken;
			end
		end
	end

endmodule

// ==== hw/ex_stage.sv ====
// Integer execute stage: ALU and multiplier in parallel, one shared CDB.
// Issue must check alu_free and mult_free before sending a request.
// cdb_credit is a one-cycle pulse per freed consumer entry.

`timescale 1ns/1ps

module ex_stage (
	input  logic              clk,
	input  logic              reset,
	input  ex_pkg::alu_req_t  alu_req,
	input  ex_pkg::mult_req_t mult_req,
	input  logic              cdb_credit,
	output ex_pkg::cdb_t      cdb,
	output logic              alu_free,
	output logic              mult_free
);
	import ex_pkg::*;

	alu_res_t  alu_res;
	mult_res_t mult_res;
	logic      alu_valid;
	logic      mult_valid;
	logic      alu_grant;
	logic      mult_grant;

	alu_unit alu_unit_i (
		.clk      (clk),
		.reset    (reset),
		.req      (alu_req),
		.grant    (alu_grant),
		.res_valid(alu_valid),
		.res      (alu_res),
		.free     (alu_free)
	);

	mult_pipe mult_pipe_i (
		.clk      (clk),
		.reset    (reset),
		.req      (mult_req),
		.grant    (mult_grant),
		.res_valid(mult_valid),
		.res      (mult_res),
		.free     (mult_free)
	);

	cdb_arbiter cdb_arbiter_i (
		.clk       (clk),
		.reset     (reset),
		.alu_valid (alu_valid),
		.alu_res   (alu_res),
		.mult_valid(mult_valid),
		.mult_res  (mult_res),
		.cdb_credit(cdb_credit),
		.alu_grant (alu_grant),
		.mult_grant(mult_grant),
		.cdb       (cdb)
	);

endmodule

// ==== test/ex_stage_asserts.sv ====
// Protocol assertions for the execute stage, bound into ex_stage.
// Issue-side checks are off while reset is high.

`timescale 1ns/1ps

module ex_stage_asserts (
	input logic              clk,
	input logic              reset,
	input ex_pkg::alu_req_t  alu_req,
	input ex_pkg::mult_req_t mult_req,
	input logic              alu_free,
	input logic              mult_free,
	input ex_pkg::cdb_t      cdb
);

	// CDB is quiet right after a reset edge
	cdb_idle_after_reset: assert property (@(posedge clk) reset |=> !cdb.valid)
		else $error("cdb.valid high in the cycle after reset");

	alu_issue_when_free: assert property (
		@(posedge clk) disable iff (reset) alu_req.valid |-> alu_free)
		else $error("ALU request issued while alu_free was low");

	mult_issue_when_free: assert property (
		@(posedge clk) disable iff (reset) mult_req.valid |-> mult_free)
		else $error("multiplier request issued while mult_free was low");

endmodule

bind ex_stage ex_stage_asserts ex_stage_asserts_i (
	.clk      (clk),
	.reset    (reset),
	.alu_req  (alu_req),
	.mult_req (mult_req),
	.alu_free (alu_free),
	.mult_free(mult_free),
	.cdb      (cdb)
);

// ==== test/ex_stage_tb.sv ====
// Testbench for the integer execute stage.
// Each table entry is tagged with its own index, so tags stay unique for up to
// 2**(PRF_IDX+ROB_IDX) entries; the ROB index is the low part of that number.
// The credit model returns only credits for broadcasts it has seen.

`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage_tb;
	import ex_pkg::*;

	localparam int TIMEOUT = 500;
	localparam logic [`XLEN-1:0] ALL1 = '1;
	localparam logic [`XLEN-1:0] SIGN = {1'b1, {(`XLEN-1){1'b0}}};

	typedef struct packed {
		logic             is_mult;
		alu_func_t        func;
		logic [2:0]       br_func;
		logic             is_branch;
		logic [`XLEN-1:0] opa;
		logic [`XLEN-1:0] opb;
		logic [`XLEN-1:0] cond_val;
		logic [`XLEN-1:0] exp_value;
		logic             exp_br;
	} table_entry_t;

	logic      clk;
	logic      reset;
	alu_req_t  alu_req;
	mult_req_t mult_req;
	logic      cdb_credit;
	cdb_t      cdb;
	logic      alu_free;
	logic      mult_free;

	table_entry_t table_q[$];
	string        names[$];
	int           alu_q[$];
	int           mult_q[$];
	int           errors = 0;
	int           timeouts = 0;
	int           issued = 0;
	int           received = 0;
	int           owed = 0;
	logic         withhold = 1'b0;
	integer       seed = 44500;

	ex_stage ex_stage_i (
		.clk       (clk),
		.reset     (reset),
		.alu_req   (alu_req),
		.mult_req  (mult_req),
		.cdb_credit(cdb_credit),
		.cdb       (cdb),
		.alu_free  (alu_free),
		.mult_free (mult_free)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// Reference branch condition for one br_func code
	function automatic logic branch_expect(logic [2:0] code, logic [`XLEN-1:0] v);
		logic r;
		case (code[1:0])
			2'b00: r = (v[0] == 1'b0);
			2'b01: r = (v == '0);
			2'b10: r = ($signed(v) < 0);
			default: r = ($signed(v) <= 0);
		endcase
		return code[2] ? ~r : r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////
	task automatic add_alu(string name, alu_func_t f, logic [`XLEN-1:0] a,
			logic [`XLEN-1:0] b, logic [`XLEN-1:0] exp_value);
		table_q.push_back('{1'b0, f, 3'd0, 1'b0, a, b, '0, exp_value, 1'b0});
		names.push_back(name);
	endtask

	// Branch entries also add opa and opb, so the value is cond + code
	task automatic add_branch(logic [2:0] code, logic [`XLEN-1:0] c, logic is_br);
		logic [`XLEN-1:0] sum;
		logic             taken;
		sum   = c + `XLEN'(code);
		taken = is_br & branch_expect(code, c);
		table_q.push_back('{1'b0, alu_addq, code, is_br, c, `XLEN'(code), c, sum, taken});
		names.push_back($sformatf("br%0d %0d cond %h", code, is_br, c));
	endtask

	task automatic add_mult(logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
		logic [`XLEN-1:0] prod;
		prod = a * b;
		table_q.push_back('{1'b1, alu_addq, 3'd0, 1'b0, a, b, '0, prod, 1'b0});
		names.push_back($sformatf("mul %0d", table_q.size() - 1));
	endtask

	function automatic logic [`XLEN-1:0] rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic build_table();
		logic [`XLEN-1:0] conds[4];
		conds = '{'0, SIGN, `XLEN'd4, `XLEN'd3};
		add_alu("addq", alu_addq, 5, 7, 12);
		add_alu("addq wrap", alu_addq, ALL1, 2, 1);
		add_alu("subq", alu_subq, 5, 7, ALL1 - 1);
		add_alu("and", alu_and, 'hff00, 'h0ff0, 'h0f00);
		add_alu("bic", alu_bic, 'hff00, 'h0ff0, 'hf000);
		add_alu("bis", alu_bis, 'hff00, 'h0ff0, 'hfff0);
		add_alu("ornot", alu_ornot, 'hff00, 'h0ff0, 64'hffff_ffff_ffff_ff0f);
		add_alu("xor", alu_xor, 'hff00, 'h0ff0, 'hf0f0);
		add_alu("eqv", alu_eqv, 'hff00, 'h0ff0, 64'hffff_ffff_ffff_0f0f);
		add_alu("srl", alu_srl, SIGN, 'h104, 64'h0800_0000_0000_0000);
		add_alu("sll", alu_sll, 1, 63, SIGN);
		add_alu("sra neg", alu_sra, SIGN, 4, 64'hf800_0000_0000_0000);
		add_alu("cmpult big", alu_cmpult, ALL1, 1, 0);
		add_alu("cmpult small", alu_cmpult, 1, ALL1, 1);
		add_alu("cmpeq same", alu_cmpeq, 5, 5, 1);
		add_alu("cmpeq diff", alu_cmpeq, 5, 6, 0);
		add_alu("cmpule", alu_cmpule, 7, 7, 1);
		add_alu("cmpule big", alu_cmpule, ALL1, 1, 0);
		add_alu("cmplt neg", alu_cmplt, ALL1, 1, 1);
		add_alu("cmplt pos", alu_cmplt, 1, ALL1, 0);
		add_alu("cmple pos", alu_cmple, 1, ALL1, 0);
		add_alu("cmple eq", alu_cmple, ALL1, ALL1, 1);
		// Back-to-back multiplies with edge operands first
		add_mult(0, rand_word());
		add_mult(1, 64'h0123_4567_89ab_cdef);
		add_mult(ALL1, ALL1);
		add_mult(SIGN, 2);
		add_mult(64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321);
		for (int i = 0; i < 5; i++)
			add_mult(rand_word(), rand_word());
		// Branches with a multiply after every fourth one
		for (int code = 0; code < 8; code++) begin
			for (int k = 0; k < 4; k++)
				add_branch(3'(code), conds[k], 1'b1);
			add_mult(rand_word(), rand_word());
		end
		add_branch(3'd1, '0, 1'b0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Issue side
	//////////////////////////////////////////////////////////////////////
	task automatic clear_requests();
		alu_req.valid  = 1'b0;
		mult_req.valid = 1'b0;
	endtask

	task automatic issue(int idx);
		table_entry_t e;
		int           t;
		e = table_q[idx];
		t = 0;
		while (!(e.is_mult ? mult_free : alu_free) && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!(e.is_mult ? mult_free : alu_free)) begin
			$display("timeout: unit for %s never became free", names[idx]);
			timeouts++;
		end else if (e.is_mult) begin
			mult_req = '{1'b1, e.opa, e.opb, ex_tag_t'(11'(idx))};
			mult_q.push_back(idx);
			issued++;
		end else begin
			alu_req = '{1'b1, e.func, e.br_func, e.is_branch, e.opa, e.opb, e.cond_val,
				ex_tag_t'(11'(idx))};
			alu_q.push_back(idx);
			issued++;
		end
	endtask

	task automatic run_entries(int first, int last);
		for (int i = first; i < last; i++) begin
			@(negedge clk);
			clear_requests();
			issue(i);
		end
		@(negedge clk);
		clear_requests();
	endtask

	task automatic wait_drain(string what);
		int t;
		t = 0;
		while (received < issued && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (received < issued) begin
			$display("timeout: %s results did not all reach the CDB", what);
			timeouts++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Consumer side with credit return and scoreboard
	//////////////////////////////////////////////////////////////////////
	initial begin
		cdb_credit = 1'b0;
		forever begin
			@(negedge clk);
			cdb_credit = 1'b0;
			if (!reset && cdb.valid === 1'b1)
				owed++;
			if (!withhold && owed > 0 && ($random(seed) & 1) == 1) begin
				cdb_credit = 1'b1;
				owed--;
			end
		end
	end

	task automatic receive_result();
		table_entry_t e;
		int           idx;
		int           want;
		idx = int'(cdb.tag);
		received++;
		if (idx >= table_q.size()) begin
			$display("error: tag %0d on the CDB was never issued", idx);
			errors++;
			return;
		end
		e = table_q[idx];
		if ((e.is_mult && mult_q.size() == 0) || (!e.is_mult && alu_q.size() == 0)) begin
			$display("error: %s arrived with no operation outstanding", names[idx]);
			errors++;
			return;
		end
		if (e.is_mult)
			want = mult_q.pop_front();
		else
			want = alu_q.pop_front();
		check({names[idx], " order"}, 64'(want), 64'(idx));
		check({names[idx], " value"}, e.exp_value, cdb.value);
		check({names[idx], " br_taken"}, 64'(e.exp_br), 64'(cdb.br_taken));
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (!reset && cdb.valid === 1'b1)
				receive_result();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		int t;
		int phase2_start;
		int sent_before;
		reset    = 1'b1;
		alu_req  = '0;
		mult_req = '0;
		build_table();
		phase2_start = table_q.size();
		for (int i = 0; i < 3; i++)
			add_alu($sformatf("stall addq %0d", i), alu_addq, 64'(i), 100, 64'(100 + i));
		for (int i = 0; i < 4; i++)
			add_mult(rand_word(), rand_word());
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Mixed traffic with random credit return
		run_entries(0, phase2_start);
		wait_drain("mixed traffic");

		// Hold credits back once all have returned
		t = 0;
		while (owed != 0 && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (owed != 0) begin
			$display("timeout: credits were not all returned");
			timeouts++;
		end
		withhold    = 1'b1;
		sent_before = received;
		run_entries(phase2_start, table_q.size());
		t = 0;
		while ((alu_free || mult_free) && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (alu_free || mult_free) begin
			$display("timeout: free signals did not drop while credits were held");
			timeouts++;
		end
		check("withheld broadcasts", `CDB_CREDITS, 64'(received - sent_before));
		withhold = 1'b0;
		wait_drain("stalled traffic");
		check("alu_free after drain", 1, 64'(alu_free));
		check("mult_free after drain", 1, 64'(mult_free));
		check("results received", 64'(issued), 64'(received));

		$display("done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== ex_stage.f ====
+incdir+hw
hw/ex_pkg.sv
hw/result_slot.sv
hw/alu_unit.sv
hw/mult_pipe.sv
hw/cdb_arbiter.sv
hw/ex_stage.sv
test/ex_stage_asserts.sv
test/ex_stage_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ex_stage_tb
FILELIST = ex_stage.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
